// ==== de_exe_if.sv ====
`timescale 1ns/100ps

interface de_exe_if;
    import rv_exe_pkg::*;

    ctrl_word_t ctrl;
    logic       valid;  // register holds an instruction
    logic       stall;  // execute busy with a multicycle op

    modport reg_mp (
        output ctrl,
        output valid,
        input  stall
    );

    modport exe_mp (
        input  ctrl,
        input  valid,
        output stall
    );

endinterface

// ==== de_exe_reg.sv ====
`timescale 1ns/100ps
`include "rv_exe_config.svh"

module de_exe_reg (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_i,
    input  rv_exe_pkg::ctrl_word_t ctrl_i,
    de_exe_if.reg_mp               bus
);

    // stall freezes the word, an issue then is dropped
    always_ff @(posedge clk) begin
        if (rst) begin
            bus.valid   <= 1'b0;
            bus.ctrl    <= '0;
            bus.ctrl.pc <= `RESET_PC;
        end else if (!bus.stall) begin
            bus.valid <= issue_i;       // bubble when nothing issued
            if (issue_i) begin
                bus.ctrl <= ctrl_i;
            end
        end
    end

endmodule

// ==== exe_alu.sv ====
`timescale 1ns/100ps
`include "rv_exe_config.svh"

module exe_alu (
    input  logic                clk,
    input  logic                rst,
    input  logic                start_i,
    input  rv_exe_pkg::alu_op_e op_i,
    input  logic [`XLEN-1:0]    a_i,
    input  logic [`XLEN-1:0]    b_i,
    output logic [`XLEN-1:0]    result_o,
    output logic                busy_o
);
    import rv_exe_pkg::*;

    localparam int CNT_W = $clog2(`MUL_LATENCY + 1);

    logic [CNT_W-1:0] cnt_q;    // busy cycles still to go
    logic [`XLEN-1:0] prod_q;
    logic             mul_start;
    logic [4:0]       shamt;

    assign shamt     = b_i[4:0];
    assign mul_start = start_i && (op_i == alu_mul);
    assign busy_o    = mul_start || (cnt_q != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (mul_start) begin
            cnt_q <= CNT_W'(`MUL_LATENCY - 2);  // first busy cycle is this one
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // operands may change while stalled, so keep the product
    always_ff @(posedge clk) begin
        if (mul_start) begin
            prod_q <= a_i * b_i;    // low word only
        end
    end

    always_comb begin
        case (op_i)
            alu_sub:  result_o = a_i - b_i;
            alu_sll:  result_o = a_i << shamt;
            alu_slt:  result_o = {{(`XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
            alu_sltu: result_o = {{(`XLEN-1){1'b0}}, a_i < b_i};
            alu_xor:  result_o = a_i ^ b_i;
            alu_srl:  result_o = a_i >> shamt;
            alu_sra:  result_o = $signed(a_i) >>> shamt;
            alu_or:   result_o = a_i | b_i;
            alu_and:  result_o = a_i & b_i;
            alu_mul:  result_o = prod_q;
            default:  result_o = a_i + b_i;     // add and address sums
        endcase
    end

endmodule

// ==== exe_stage.sv ====
`timescale 1ns/100ps
`include "rv_exe_config.svh"

module exe_stage (
    input  logic             clk,
    input  logic             rst,
    de_exe_if.exe_mp         bus,
    input  logic [`XLEN-1:0] exe_fwd_data_i,
    input  logic [`XLEN-1:0] mem_fwd_data_i,
    input  logic [`XLEN-1:0] wb_fwd_data_i,
    output logic             result_valid_o,
    output logic             rd_we_o,
    output logic [4:0]       rd_addr_o,
    output logic [`XLEN-1:0] rd_data_o,
    output logic             br_taken_o,
    output logic             mispredict_o,
    output logic [`XLEN-1:0] redirect_pc_o
);
    import rv_exe_pkg::*;

    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] target;
    logic             stall_q;      // word in register is a held one
    logic             alu_start;
    logic             alu_busy;
    logic             cmp_true;
    logic             taken;
    logic             is_br;
    logic             is_jal;
    logic             is_jalr;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input fwd_sel_e         sel,
        input logic [`XLEN-1:0] reg_data,
        input logic [`XLEN-1:0] exe_data,
        input logic [`XLEN-1:0] mem_data,
        input logic [`XLEN-1:0] wb_data
    );
        case (sel)
            fwd_exe: return exe_data;
            fwd_mem: return mem_data;
            fwd_wb:  return wb_data;
            default: return reg_data;
        endcase
    endfunction

    assign rs1_val = fwd_mux(bus.ctrl.rs1_sel, bus.ctrl.rs1_data,
                             exe_fwd_data_i, mem_fwd_data_i, wb_fwd_data_i);
    assign rs2_val = fwd_mux(bus.ctrl.rs2_sel, bus.ctrl.rs2_data,
                             exe_fwd_data_i, mem_fwd_data_i, wb_fwd_data_i);

    assign alu_a = (bus.ctrl.alu_a_sel == a_pc) ? bus.ctrl.pc : rs1_val;
    assign alu_b = (bus.ctrl.alu_b_sel == b_imm) ? bus.ctrl.imm : rs2_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= bus.stall;
        end
    end

    assign alu_start = bus.valid && !stall_q;   // first cycle of a new word
    assign bus.stall = alu_busy;

    exe_alu i_exe_alu (
        .clk      (clk),
        .rst      (rst),
        .start_i  (alu_start),
        .op_i     (bus.ctrl.alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result),
        .busy_o   (alu_busy)
    );

    always_comb begin
        case (bus.ctrl.cmp_op)
            cmp_beq:  cmp_true = rs1_val == rs2_val;
            cmp_bne:  cmp_true = rs1_val != rs2_val;
            cmp_blt:  cmp_true = $signed(rs1_val) < $signed(rs2_val);
            cmp_bge:  cmp_true = $signed(rs1_val) >= $signed(rs2_val);
            cmp_bltu: cmp_true = rs1_val < rs2_val;
            cmp_bgeu: cmp_true = rs1_val >= rs2_val;
            default:  cmp_true = 1'b0;
        endcase
    end

    assign is_br   = bus.ctrl.opcode == op_br;
    assign is_jal  = bus.ctrl.opcode == op_jal;
    assign is_jalr = bus.ctrl.opcode == op_jalr;

    assign taken    = (is_br && cmp_true) || is_jal || is_jalr;
    assign pc_plus4 = bus.ctrl.pc + `XLEN'd4;
    assign target   = is_jalr ? {alu_result[`XLEN-1:1], 1'b0} : alu_result;

    assign result_valid_o = bus.valid && !bus.stall;
    assign rd_we_o        = result_valid_o && bus.ctrl.rd_we;
    assign rd_addr_o      = bus.ctrl.rd_addr;
    assign rd_data_o      = (is_jal || is_jalr) ? pc_plus4 : alu_result;  // link value
    assign br_taken_o     = result_valid_o && taken;
    assign redirect_pc_o  = taken ? target : pc_plus4;

    // jalr target is never predicted
    assign mispredict_o = result_valid_o &&
                          (((is_br || is_jal) && (taken != bus.ctrl.prediction)) || is_jalr);

endmodule

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tb_rv_exe -f verilog.f -o tb_rv_exe || exit 1
./obj_dir/tb_rv_exe > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1 || echo "no failure found in sim.log"

// ==== rv_decoder.sv ====
`timescale 1ns/100ps
`include "rv_exe_config.svh"

module rv_decoder (
    input  logic [31:0]            instr_i,
    input  logic [`XLEN-1:0]       pc_i,
    input  logic [`XLEN-1:0]       rs1_data_i,
    input  logic [`XLEN-1:0]       rs2_data_i,
    input  logic                   prediction_i,
    input  rv_exe_pkg::fwd_sel_e   rs1_fwd_sel_i,
    input  rv_exe_pkg::fwd_sel_e   rs2_fwd_sel_i,
    output rv_exe_pkg::ctrl_word_t ctrl_o
);
    import rv_exe_pkg::*;

    rv_opcode_e       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [4:0]       rd;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;

    // funct3 to ALU op, alt picks sub or sra
    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    assign opcode = rv_opcode_e'(instr_i[6:0]);
    assign rd     = instr_i[11:7];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {instr_i[31:12], 12'h000};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        ctrl_o.opcode     = opcode;
        ctrl_o.alu_op     = alu_add;
        ctrl_o.cmp_op     = cmp_beq;
        ctrl_o.rs1_sel    = rs1_fwd_sel_i;
        ctrl_o.rs2_sel    = rs2_fwd_sel_i;
        ctrl_o.alu_a_sel  = a_rs1;
        ctrl_o.alu_b_sel  = b_imm;
        ctrl_o.imm        = imm_i;
        ctrl_o.pc         = pc_i;
        ctrl_o.rs1_data   = rs1_data_i;
        ctrl_o.rs2_data   = rs2_data_i;
        ctrl_o.rd_addr    = rd;
        ctrl_o.rd_we      = 1'b1;
        ctrl_o.prediction = prediction_i;
        case (opcode)
            op_reg: begin
                ctrl_o.alu_b_sel = b_rs2;
                ctrl_o.alu_op    = funct7[0] ? alu_mul : arith_op(funct3, funct7[5]);
            end
            op_imm: begin
                ctrl_o.alu_op = arith_op(funct3, (funct3 == 3'b101) && funct7[5]);  // no subi
            end
            op_lui: begin
                ctrl_o.imm      = imm_u;
                ctrl_o.rs1_sel  = fwd_regfile;  // 0 + imm
                ctrl_o.rs1_data = '0;
            end
            op_auipc: begin
                ctrl_o.imm       = imm_u;
                ctrl_o.alu_a_sel = a_pc;
            end
            op_br: begin
                ctrl_o.imm       = imm_b;
                ctrl_o.alu_a_sel = a_pc;        // alu gives the target
                ctrl_o.cmp_op    = cmp_op_e'(funct3);
                ctrl_o.rd_we     = 1'b0;
            end
            op_jal: begin
                ctrl_o.imm       = imm_j;
                ctrl_o.alu_a_sel = a_pc;
            end
            op_jalr: begin
                ctrl_o.alu_a_sel = a_rs1;       // rs1 + imm
            end
            default: begin
                ctrl_o.rd_we = 1'b0;
            end
        endcase
        if (rd == 5'd0) begin
            ctrl_o.rd_we = 1'b0;
        end
    end

endmodule

// ==== rv_exe_config.svh ====
`ifndef RV_EXE_CONFIG_SVH
`define RV_EXE_CONFIG_SVH

// datapath and address width
`define XLEN 32

`define RESET_PC 32'h40000000   // pc seen in an empty register

`define MUL_LATENCY 4           // cycles a multiply holds execute

`endif

// ==== rv_exe_pkg.sv ====
`include "rv_exe_config.svh"

package rv_exe_pkg;

    typedef enum logic [6:0] {
        op_reg   = 7'b0110011,
        op_imm   = 7'b0010011,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_br    = 7'b1100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111
    } rv_opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_mul         // low word only
    } alu_op_e;

    // same values as branch funct3
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {fwd_regfile, fwd_exe, fwd_mem, fwd_wb} fwd_sel_e;

    typedef enum logic {a_rs1, a_pc} alu_a_sel_e;

    typedef enum logic {b_rs2, b_imm} alu_b_sel_e;

    typedef struct packed {
        rv_opcode_e       opcode;
        alu_op_e          alu_op;
        cmp_op_e          cmp_op;
        fwd_sel_e         rs1_sel;
        fwd_sel_e         rs2_sel;
        alu_a_sel_e       alu_a_sel;
        alu_b_sel_e       alu_b_sel;
        logic [`XLEN-1:0] imm;          // already extended
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [4:0]       rd_addr;
        logic             rd_we;
        logic             prediction;   // fetch predicted taken
    } ctrl_word_t;

endpackage

// ==== rv_exe_top.sv ====
`timescale 1ns/100ps
`include "rv_exe_config.svh"

module rv_exe_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_i,
    input  logic [31:0]      instr_i,
    input  logic [`XLEN-1:0] pc_i,
    input  logic [`XLEN-1:0] rs1_data_i,
    input  logic [`XLEN-1:0] rs2_data_i,
    input  logic             prediction_i,
    input  logic [1:0]       rs1_fwd_sel_i,
    input  logic [1:0]       rs2_fwd_sel_i,
    input  logic [`XLEN-1:0] exe_fwd_data_i,
    input  logic [`XLEN-1:0] mem_fwd_data_i,
    input  logic [`XLEN-1:0] wb_fwd_data_i,
    output logic             ready_o,
    output logic             result_valid_o,
    output logic             rd_we_o,
    output logic [4:0]       rd_addr_o,
    output logic [`XLEN-1:0] rd_data_o,
    output logic             br_taken_o,
    output logic             mispredict_o,
    output logic [`XLEN-1:0] redirect_pc_o
);
    import rv_exe_pkg::*;

    ctrl_word_t dec_ctrl;

    de_exe_if de_exe ();

    rv_decoder i_rv_decoder (
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .prediction_i  (prediction_i),
        .rs1_fwd_sel_i (fwd_sel_e'(rs1_fwd_sel_i)),
        .rs2_fwd_sel_i (fwd_sel_e'(rs2_fwd_sel_i)),
        .ctrl_o        (dec_ctrl)
    );

    de_exe_reg i_de_exe_reg (
        .clk     (clk),
        .rst     (rst),
        .issue_i (issue_i),
        .ctrl_i  (dec_ctrl),
        .bus     (de_exe.reg_mp)
    );

    exe_stage i_exe_stage (
        .clk            (clk),
        .rst            (rst),
        .bus            (de_exe.exe_mp),
        .exe_fwd_data_i (exe_fwd_data_i),
        .mem_fwd_data_i (mem_fwd_data_i),
        .wb_fwd_data_i  (wb_fwd_data_i),
        .result_valid_o (result_valid_o),
        .rd_we_o        (rd_we_o),
        .rd_addr_o      (rd_addr_o),
        .rd_data_o      (rd_data_o),
        .br_taken_o     (br_taken_o),
        .mispredict_o   (mispredict_o),
        .redirect_pc_o  (redirect_pc_o)
    );

    assign ready_o = !de_exe.stall;    // no issue while a multiply runs

endmodule

// ==== tb_rv_exe.sv ====
`timescale 1ns/100ps
`include "rv_exe_config.svh"

module tb_rv_exe;

    localparam int NUM_INSTR   = 54;
    localparam int CYCLE_LIMIT = NUM_INSTR * `MUL_LATENCY + 40;  // margin covers reset

    logic        clk;
    logic        rst;
    logic        issue_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_data_i;
    logic [31:0] rs2_data_i;
    logic        prediction_i;
    logic [1:0]  rs1_fwd_sel_i;
    logic [1:0]  rs2_fwd_sel_i;
    logic [31:0] exe_fwd_data_i;
    logic [31:0] mem_fwd_data_i;
    logic [31:0] wb_fwd_data_i;
    logic        ready_o;
    logic        result_valid_o;
    logic        rd_we_o;
    logic [4:0]  rd_addr_o;
    logic [31:0] rd_data_o;
    logic        br_taken_o;
    logic        mispredict_o;
    logic [31:0] redirect_pc_o;
    logic [31:0] lfsr_q = 32'hd0971a23;
    int          cycle_cnt = 0;

    rv_exe_top i_rv_exe_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $fatal(1);
        end
    end

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, 5'd2, 5'd1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] op);
        return {imm, 5'd1, f3, rd, op};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // rv32i arithmetic by funct3 where alt is funct7 bit 5
    function automatic logic [31:0] arith_ref(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic signed [31:0] sra_val;
        sra_val = $signed(a) >>> b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? sra_val : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic clock_edge();
        @(posedge clk);
        #2;     // drive point
    endtask

    task automatic drive_instr(input logic [31:0] instr, input logic [31:0] pc,
                               input logic [31:0] a, input logic [31:0] b, input logic pred,
                               input logic [1:0] s1, input logic [1:0] s2);
        instr_i        = instr;
        pc_i           = pc;
        rs1_data_i     = a;
        rs2_data_i     = b;
        prediction_i   = pred;
        rs1_fwd_sel_i  = s1;
        rs2_fwd_sel_i  = s2;
        exe_fwd_data_i = rand_bits(32);
        mem_fwd_data_i = rand_bits(32);
        wb_fwd_data_i  = rand_bits(32);
        issue_i        = 1'b1;
    endtask

    // issue once and sample mid-cycle while the word sits in the register
    task automatic exec_instr(input logic [31:0] instr, input logic [31:0] pc,
                              input logic [31:0] a, input logic [31:0] b, input logic pred,
                              input logic [1:0] s1, input logic [1:0] s2);
        clock_edge();
        drive_instr(instr, pc, a, b, pred, s1, s2);
        clock_edge();
        issue_i = 1'b0;
        @(negedge clk);
    endtask

    task automatic check_write(input logic [4:0] rd, input logic [31:0] data);
        expect_eq("result_valid_o", 1, result_valid_o);
        expect_eq("rd_we_o", 1, rd_we_o);
        expect_eq("rd_addr_o", rd, rd_addr_o);
        expect_eq("rd_data_o", data, rd_data_o);
    endtask

    task automatic check_flow(input logic taken, input logic mis, input logic [31:0] redirect);
        expect_eq("br_taken_o", taken, br_taken_o);
        expect_eq("mispredict_o", mis, mispredict_o);
        expect_eq("redirect_pc_o", redirect, redirect_pc_o);
    endtask

    task automatic reset_and_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] instr;
        logic [11:0] imm;
        logic [19:0] uimm;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic        alt;
        logic        ir;
        int          idx;
        expect_eq("ready_o", 1, ready_o);
        expect_eq("result_valid_o", 0, result_valid_o);
        expect_eq("rd_we_o", 0, rd_we_o);
        check_flow(1'b0, 1'b0, `RESET_PC + 32'd4);
        for (int k = 0; k < 20; k++) begin
            ir  = k >= 10;
            idx = k % 10;
            if (ir && idx == 8) continue;   // no subi
            f3  = (idx < 8) ? 3'(idx) : ((idx == 8) ? 3'd0 : 3'd5);
            alt = idx >= 8;
            rd  = 5'(idx + 1);
            a   = rand_bits(32);
            pc  = rand_bits(30) << 2;
            if (ir) begin
                imm   = (f3 == 3'd1 || f3 == 3'd5) ? {1'b0, alt, 5'd0, 5'(rand_bits(5))}
                                                   : 12'(rand_bits(12));
                b     = {{20{imm[11]}}, imm};
                instr = i_type(imm, f3, rd, 7'b0010011);
            end else begin
                b     = rand_bits(32);
                instr = r_type({1'b0, alt, 5'd0}, f3, rd);
            end
            exec_instr(instr, pc, a, b, 1'b0, 2'd0, 2'd0);
            check_write(rd, arith_ref(f3, alt, a, b));
            check_flow(1'b0, 1'b0, pc + 32'd4);
        end
        uimm = 20'(rand_bits(20));
        pc   = rand_bits(30) << 2;
        exec_instr(u_type(uimm, 5'd5, 7'b0110111), pc, rand_bits(32), 0, 1'b0, 2'd1, 2'd0);
        check_write(5'd5, {uimm, 12'h000});
        exec_instr(u_type(uimm, 5'd6, 7'b0010111), pc, rand_bits(32), 0, 1'b0, 2'd0, 2'd0);
        check_write(5'd6, pc + {uimm, 12'h000});
    endtask

    task automatic forwarding_paths();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] fwd;
        for (int s = 1; s < 4; s++) begin
            for (int side = 0; side < 2; side++) begin
                a = rand_bits(32);
                b = rand_bits(32);
                exec_instr(r_type(7'h20, 3'd0, 5'd7), 32'h100, a, b, 1'b0,
                           (side == 0) ? 2'(s) : 2'd0, (side == 1) ? 2'(s) : 2'd0);
                fwd = (s == 1) ? exe_fwd_data_i : ((s == 2) ? mem_fwd_data_i : wb_fwd_data_i);
                check_write(5'd7, (side == 0) ? fwd - b : a - fwd);   // sub shows the order
            end
        end
    endtask

    task automatic branch_compares();
        logic [31:0] lo;
        logic [31:0] hi;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [12:0] imm;
        logic [2:0]  f3;
        logic        pred;
        logic        taken;
        for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? 3'(c) : 3'(c + 2);
            lo = {1'b1, 31'(rand_bits(31))};    // below hi signed and above it unsigned
            hi = {1'b0, 31'(rand_bits(31))};
            for (int p = 0; p < 3; p++) begin
                a     = (p == 2) ? hi : lo;
                b     = (p == 1) ? hi : lo;
                imm   = 13'(rand_bits(12)) << 1;
                pc    = rand_bits(30) << 2;
                pred  = 1'(rand_bits(1));
                taken = branch_ref(f3, a, b);
                exec_instr(b_type(imm, f3), pc, a, b, pred, 2'd0, 2'd0);
                expect_eq("result_valid_o", 1, result_valid_o);
                expect_eq("rd_we_o", 0, rd_we_o);
                check_flow(taken, taken ^ pred,
                           taken ? pc + {{19{imm[12]}}, imm} : pc + 32'd4);
            end
        end
    endtask

    task automatic jump_targets();
        logic [31:0] a;
        logic [31:0] pc;
        logic [20:0] jimm;
        logic [11:0] imm;
        for (int p = 0; p < 2; p++) begin
            jimm = 21'(rand_bits(20)) << 1;
            pc   = rand_bits(30) << 2;
            exec_instr(j_type(jimm, 5'd1), pc, 0, 0, 1'(p), 2'd0, 2'd0);
            check_write(5'd1, pc + 32'd4);
            check_flow(1'b1, p == 0, pc + {{11{jimm[20]}}, jimm});
        end
        for (int p = 0; p < 2; p++) begin
            a   = rand_bits(32) | 32'd1;        // odd sum forces bit 0 to be cleared
            imm = 12'(rand_bits(11)) << 1;
            pc  = rand_bits(30) << 2;
            exec_instr(i_type(imm, 3'd0, 5'd2, 7'b1100111), pc, a, 0, 1'(p), 2'd0, 2'd0);
            check_write(5'd2, pc + 32'd4);
            check_flow(1'b1, 1'b1, (a + {{20{imm[11]}}, imm}) & ~32'd1);
        end
    endtask

    task automatic multiply_stall();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        int          n;
        a = rand_bits(32);
        b = rand_bits(32);
        c = rand_bits(32);
        d = rand_bits(32);
        clock_edge();
        drive_instr(r_type(7'h01, 3'd0, 5'd9), 32'h200, a, b, 1'b0, 2'd0, 2'd0);
        clock_edge();
        issue_i = 1'b0;
        expect_eq("ready_o", 0, ready_o);
        n = 1;
        while (!ready_o && n < 2 * `MUL_LATENCY) begin
            expect_eq("result_valid_o", 0, result_valid_o);
            clock_edge();
            n++;
        end
        expect_eq("multiply latency", `MUL_LATENCY, n);
        // next add goes in on the first edge with ready high
        drive_instr(r_type(7'h00, 3'd0, 5'd10), 32'h204, c, d, 1'b0, 2'd0, 2'd0);
        @(negedge clk);
        check_write(5'd9, a * b);
        clock_edge();
        issue_i = 1'b0;
        @(negedge clk);
        check_write(5'd10, c + d);
        expect_eq("ready_o", 1, ready_o);
    endtask

    task automatic back_to_back();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        a = rand_bits(32);
        b = rand_bits(32);
        c = rand_bits(32);
        d = rand_bits(32);
        clock_edge();
        drive_instr(r_type(7'h00, 3'd0, 5'd11), 32'h300, a, b, 1'b0, 2'd0, 2'd0);
        clock_edge();
        drive_instr(r_type(7'h00, 3'd4, 5'd12), 32'h304, c, d, 1'b0, 2'd0, 2'd0);
        @(negedge clk);
        check_write(5'd11, a + b);
        clock_edge();
        drive_instr(32'h0010_2583, 32'h308, a, b, 1'b1, 2'd0, 2'd0);   // unsupported load
        @(negedge clk);
        check_write(5'd12, c ^ d);
        clock_edge();
        issue_i = 1'b0;
        @(negedge clk);
        expect_eq("result_valid_o", 1, result_valid_o);
        expect_eq("rd_we_o", 0, rd_we_o);
        expect_eq("mispredict_o", 0, mispredict_o);
    endtask

    initial begin
        rst            = 1'b1;
        issue_i        = 1'b0;
        instr_i        = '0;
        pc_i           = '0;
        rs1_data_i     = '0;
        rs2_data_i     = '0;
        prediction_i   = 1'b0;
        rs1_fwd_sel_i  = 2'd0;
        rs2_fwd_sel_i  = 2'd0;
        exe_fwd_data_i = '0;
        mem_fwd_data_i = '0;
        wb_fwd_data_i  = '0;
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        @(negedge clk);
        reset_and_alu();
        forwarding_paths();
        branch_compares();
        jump_targets();
        multiply_stall();
        back_to_back();
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
rv_exe_pkg.sv
de_exe_if.sv
rv_decoder.sv
de_exe_reg.sv
exe_alu.sv
exe_stage.sv
rv_exe_top.sv
tb_rv_exe.sv
